// File: bus_pkg.sv
////////////////////////////////////////
// Bus widths and typed vectors for the
// OBI memory side and the register port
////////////////////////////////////////

`default_nettype none

package bus_pkg;

  // OBI memory side, byte addressed, one word per beat
  localparam int OBI_ADDR_W = 32;
  localparam int OBI_DATA_W = 32;
  localparam int OBI_BE_W   = OBI_DATA_W / 8;

  // Register port offset width
  localparam int REG_ADDR_W = 5;

  typedef logic [OBI_ADDR_W-1:0] obi_addr_t;
  typedef logic [OBI_DATA_W-1:0] obi_data_t;
  typedef logic [OBI_BE_W-1:0]   obi_be_t;

endpackage

`default_nettype wire

// File: memcopy_pkg.sv
////////////////////////////////////////
// Memory-copy register map, copy engine
// states and word count width
////////////////////////////////////////

`default_nettype none

package memcopy_pkg;

  // Width of the word count register
  localparam int SIZE_W = 16;

  // Register offsets, one word apart
  typedef enum logic [bus_pkg::REG_ADDR_W-1:0] {
    REG_SRC    = 5'h00,
    REG_DST    = 5'h04,
    REG_SIZE   = 5'h08,
    REG_START  = 5'h0C,
    REG_STATUS = 5'h10
  } memcopy_reg_e;

  // One read then one write per word
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RD_REQ,
    ST_RD_WAIT,
    ST_WR_REQ,
    ST_WR_WAIT
  } copy_state_e;

endpackage

`default_nettype wire

// File: memcopy_regs.sv
////////////////////////////////////////
// Memory-copy register port: pointers,
// size, start pulse and status
////////////////////////////////////////

`default_nettype none

module memcopy_regs (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           reg_valid_i,
  input  logic                           reg_write_i,
  input  logic [bus_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  bus_pkg::obi_data_t             reg_wdata_i,
  output bus_pkg::obi_data_t             reg_rdata_o,
  output logic                           reg_ready_o,
  output logic                           reg_error_o,
  input  logic                           busy_i,
  input  logic                           done_i,
  output logic                           start_o,
  output bus_pkg::obi_addr_t             src_o,
  output bus_pkg::obi_addr_t             dst_o,
  output logic [memcopy_pkg::SIZE_W-1:0] size_o
);

  import bus_pkg::*;
  import memcopy_pkg::*;

  memcopy_reg_e      reg_sel;
  obi_addr_t         src_q;
  obi_addr_t         dst_q;
  logic [SIZE_W-1:0] size_q;
  logic              done_q;
  obi_data_t         rdata;
  logic              acc_err;
  logic              wr_en;

  assign reg_sel = memcopy_reg_e'(reg_addr_i);

  // Offset decode, read mux and error check
  always_comb begin
    rdata   = '0;
    acc_err = 1'b0;
    case (reg_sel)
      REG_SRC:    rdata = src_q;
      REG_DST:    rdata = dst_q;
      REG_SIZE:   rdata = obi_data_t'(size_q);
      // Write only, and refused while a copy runs
      REG_START:  acc_err = !reg_write_i || busy_i;
      REG_STATUS: begin
        // Bit 1 done, bit 0 busy
        rdata   = obi_data_t'({done_q, busy_i});
        acc_err = reg_write_i;
      end
      default:    acc_err = 1'b1;
    endcase
  end

  // Single-cycle transfers
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i && acc_err;
  assign reg_rdata_o = (reg_valid_i && !reg_write_i && !acc_err) ? rdata : '0;

  assign wr_en   = reg_valid_i && reg_write_i && !acc_err;
  assign start_o = wr_en && (reg_sel == REG_START);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q  <= '0;
      dst_q  <= '0;
      size_q <= '0;
    end else if (wr_en) begin
      case (reg_sel)
        REG_SRC:  src_q  <= reg_wdata_i;
        REG_DST:  dst_q  <= reg_wdata_i;
        REG_SIZE: size_q <= reg_wdata_i[SIZE_W-1:0];
        default:  ;
      endcase
    end
  end

  // Sticky done, a new start wins over a done in the same cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else if (start_o) begin
      done_q <= 1'b0;
    end else if (done_i) begin
      done_q <= 1'b1;
    end
  end

  assign src_o  = src_q;
  assign dst_o  = dst_q;
  assign size_o = size_q;

endmodule

`default_nettype wire

// File: memcopy_engine.sv
////////////////////////////////////////
// Copy engine FSM, one OBI read then
// one OBI write per word
////////////////////////////////////////

`default_nettype none

module memcopy_engine (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           start_i,
  input  bus_pkg::obi_addr_t             src_i,
  input  bus_pkg::obi_addr_t             dst_i,
  input  logic [memcopy_pkg::SIZE_W-1:0] size_i,
  output logic                           busy_o,
  output logic                           done_o,
  output logic                           m_req_o,
  input  logic                           m_gnt_i,
  output logic                           m_we_o,
  output bus_pkg::obi_addr_t             m_addr_o,
  output bus_pkg::obi_data_t             m_wdata_o,
  output bus_pkg::obi_be_t               m_be_o,
  input  bus_pkg::obi_data_t             m_rdata_i,
  input  logic                           m_rvalid_i
);

  import bus_pkg::*;
  import memcopy_pkg::*;

  copy_state_e       state_q;
  copy_state_e       state_d;
  obi_addr_t         src_q;
  obi_addr_t         dst_q;
  logic [SIZE_W-1:0] count_q;
  obi_data_t         data_q;
  logic              done_q;
  logic              done_d;
  logic              empty;
  logic              last_word;
  logic              wr_resp;

  assign empty     = (count_q == '0);
  assign last_word = (count_q == SIZE_W'(1));
  assign wr_resp   = (state_q == ST_WR_WAIT) && m_rvalid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_RD_REQ;
        end
      end
      ST_RD_REQ: begin
        // Nothing left to copy, finish without touching memory
        if (empty) begin
          state_d = ST_IDLE;
        end else if (m_gnt_i) begin
          state_d = ST_RD_WAIT;
        end
      end
      ST_RD_WAIT: begin
        if (m_rvalid_i) begin
          state_d = ST_WR_REQ;
        end
      end
      ST_WR_REQ: begin
        if (m_gnt_i) begin
          state_d = ST_WR_WAIT;
        end
      end
      ST_WR_WAIT: begin
        if (m_rvalid_i) begin
          state_d = last_word ? ST_IDLE : ST_RD_REQ;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // Done after the last write response, or right away for size zero
  assign done_d = ((state_q == ST_RD_REQ) && empty) || (wr_resp && last_word);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      src_q   <= '0;
      dst_q   <= '0;
      count_q <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
      if ((state_q == ST_IDLE) && start_i) begin
        src_q   <= src_i;
        dst_q   <= dst_i;
        count_q <= size_i;
      end else if (wr_resp) begin
        src_q   <= src_q + obi_addr_t'(4);
        dst_q   <= dst_q + obi_addr_t'(4);
        count_q <= count_q - SIZE_W'(1);
      end
    end
  end

  // Word in transit between read and write
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_RD_WAIT) && m_rvalid_i) begin
      data_q <= m_rdata_i;
    end
  end

  // Request fields come from registers only, so they hold until gnt
  assign m_req_o   = ((state_q == ST_RD_REQ) && !empty) || (state_q == ST_WR_REQ);
  assign m_we_o    = (state_q == ST_WR_REQ);
  assign m_addr_o  = (state_q == ST_WR_REQ) ? dst_q : src_q;
  assign m_wdata_o = m_we_o ? data_q : '0;
  assign m_be_o    = '1;

  assign busy_o = (state_q != ST_IDLE);
  assign done_o = done_q;

endmodule

`default_nettype wire

// File: obi_arbiter.sv
////////////////////////////////////////
// Two-master OBI arbiter, host first,
// owner locked until its rvalid
////////////////////////////////////////

`default_nettype none

module obi_arbiter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               host_req_i,
  input  logic               host_we_i,
  input  bus_pkg::obi_addr_t host_addr_i,
  input  bus_pkg::obi_data_t host_wdata_i,
  input  bus_pkg::obi_be_t   host_be_i,
  output logic               host_gnt_o,
  output bus_pkg::obi_data_t host_rdata_o,
  output logic               host_rvalid_o,
  input  logic               eng_req_i,
  input  logic               eng_we_i,
  input  bus_pkg::obi_addr_t eng_addr_i,
  input  bus_pkg::obi_data_t eng_wdata_i,
  input  bus_pkg::obi_be_t   eng_be_i,
  output logic               eng_gnt_o,
  output bus_pkg::obi_data_t eng_rdata_o,
  output logic               eng_rvalid_o,
  output logic               s_req_o,
  output logic               s_we_o,
  output bus_pkg::obi_addr_t s_addr_o,
  output bus_pkg::obi_data_t s_wdata_o,
  output bus_pkg::obi_be_t   s_be_o,
  input  logic               s_gnt_i,
  input  bus_pkg::obi_data_t s_rdata_i,
  input  logic               s_rvalid_i
);

  logic lock_q;
  logic host_own_q;
  logic host_sel;

  // Free slave: host wins a tie. Locked: keep the owner
  assign host_sel = lock_q ? host_own_q : host_req_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q     <= 1'b0;
      host_own_q <= 1'b0;
    end else if (!lock_q) begin
      if (host_req_i || eng_req_i) begin
        lock_q     <= 1'b1;
        host_own_q <= host_req_i;
      end
    end else if (s_rvalid_i && !(s_req_o && s_gnt_i)) begin
      lock_q <= 1'b0;
    end
  end

  assign s_req_o   = host_sel ? host_req_i   : eng_req_i;
  assign s_we_o    = host_sel ? host_we_i    : eng_we_i;
  assign s_addr_o  = host_sel ? host_addr_i  : eng_addr_i;
  assign s_wdata_o = host_sel ? host_wdata_i : eng_wdata_i;
  assign s_be_o    = host_sel ? host_be_i    : eng_be_i;

  // Grant and response go to the owner only
  assign host_gnt_o    = host_sel && s_gnt_i;
  assign eng_gnt_o     = !host_sel && s_gnt_i;
  assign host_rvalid_o = lock_q && host_own_q && s_rvalid_i;
  assign eng_rvalid_o  = lock_q && !host_own_q && s_rvalid_i;
  assign host_rdata_o  = host_rvalid_o ? s_rdata_i : '0;
  assign eng_rdata_o   = eng_rvalid_o ? s_rdata_i : '0;

endmodule

`default_nettype wire

// File: slow_memory.sv
////////////////////////////////////////
// Word memory with OBI port and grant
// delay taken from address bits 3:2
////////////////////////////////////////

`default_nettype none

module slow_memory #(
  parameter int NUM_WORDS = 128
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  bus_pkg::obi_addr_t addr_i,
  input  bus_pkg::obi_data_t wdata_i,
  input  bus_pkg::obi_be_t   be_i,
  output logic               gnt_o,
  output bus_pkg::obi_data_t rdata_o,
  output logic               rvalid_o
);

  import bus_pkg::*;

  localparam int IDX_W = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;

  obi_data_t        mem_q [NUM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [1:0]       wait_q;
  obi_data_t        rdata_q;
  logic             rvalid_q;

  // Word address wraps at the memory depth
  assign idx = IDX_W'(addr_i[OBI_ADDR_W-1:2] % NUM_WORDS);

  // Grant once the request has been held for addr[3:2] extra cycles
  assign gnt_o = req_i && (wait_q == addr_i[3:2]);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q <= '0;
    end else if (req_i && !gnt_o) begin
      wait_q <= wait_q + 2'd1;
    end else begin
      wait_q <= '0;
    end
  end

  // Byte-enabled write
  always_ff @(posedge clk_i) begin
    if (gnt_o && we_i) begin
      for (int b = 0; b < OBI_BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Response one cycle after the grant, also for writes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= gnt_o;
      if (gnt_o && !we_i) begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

endmodule

`default_nettype wire

// File: memcopy_subsys.sv
////////////////////////////////////////
// Memory-copy subsystem top: registers,
// engine, arbiter and slow memory
////////////////////////////////////////

`default_nettype none

module memcopy_subsys #(
  parameter int NUM_WORDS = 128
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           reg_valid_i,
  input  logic                           reg_write_i,
  input  logic [bus_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  bus_pkg::obi_data_t             reg_wdata_i,
  output bus_pkg::obi_data_t             reg_rdata_o,
  output logic                           reg_ready_o,
  output logic                           reg_error_o,
  input  logic                           host_req_i,
  input  logic                           host_we_i,
  input  bus_pkg::obi_addr_t             host_addr_i,
  input  bus_pkg::obi_data_t             host_wdata_i,
  input  bus_pkg::obi_be_t               host_be_i,
  output logic                           host_gnt_o,
  output bus_pkg::obi_data_t             host_rdata_o,
  output logic                           host_rvalid_o,
  output logic                           done_irq_o
);

  import bus_pkg::*;
  import memcopy_pkg::*;

  // Register file to engine
  logic              start;
  obi_addr_t         src;
  obi_addr_t         dst;
  logic [SIZE_W-1:0] size;
  logic              busy;

  // Engine master port
  logic      eng_req;
  logic      eng_gnt;
  logic      eng_we;
  obi_addr_t eng_addr;
  obi_data_t eng_wdata;
  obi_be_t   eng_be;
  obi_data_t eng_rdata;
  logic      eng_rvalid;

  // Arbiter to memory
  logic      mem_req;
  logic      mem_gnt;
  logic      mem_we;
  obi_addr_t mem_addr;
  obi_data_t mem_wdata;
  obi_be_t   mem_be;
  obi_data_t mem_rdata;
  logic      mem_rvalid;

  memcopy_regs regs_i (
    .clk_i,
    .rst_n_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .reg_ready_o,
    .reg_error_o,
    .busy_i (busy),
    .done_i (done_irq_o),
    .start_o(start),
    .src_o  (src),
    .dst_o  (dst),
    .size_o (size)
  );

  memcopy_engine engine_i (
    .clk_i,
    .rst_n_i,
    .start_i   (start),
    .src_i     (src),
    .dst_i     (dst),
    .size_i    (size),
    .busy_o    (busy),
    .done_o    (done_irq_o),
    .m_req_o   (eng_req),
    .m_gnt_i   (eng_gnt),
    .m_we_o    (eng_we),
    .m_addr_o  (eng_addr),
    .m_wdata_o (eng_wdata),
    .m_be_o    (eng_be),
    .m_rdata_i (eng_rdata),
    .m_rvalid_i(eng_rvalid)
  );

  obi_arbiter arbiter_i (
    .clk_i,
    .rst_n_i,
    .host_req_i,
    .host_we_i,
    .host_addr_i,
    .host_wdata_i,
    .host_be_i,
    .host_gnt_o,
    .host_rdata_o,
    .host_rvalid_o,
    .eng_req_i   (eng_req),
    .eng_we_i    (eng_we),
    .eng_addr_i  (eng_addr),
    .eng_wdata_i (eng_wdata),
    .eng_be_i    (eng_be),
    .eng_gnt_o   (eng_gnt),
    .eng_rdata_o (eng_rdata),
    .eng_rvalid_o(eng_rvalid),
    .s_req_o     (mem_req),
    .s_we_o      (mem_we),
    .s_addr_o    (mem_addr),
    .s_wdata_o   (mem_wdata),
    .s_be_o      (mem_be),
    .s_gnt_i     (mem_gnt),
    .s_rdata_i   (mem_rdata),
    .s_rvalid_i  (mem_rvalid)
  );

  slow_memory #(
    .NUM_WORDS(NUM_WORDS)
  ) slow_ram_i (
    .clk_i,
    .rst_n_i,
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .gnt_o   (mem_gnt),
    .rdata_o (mem_rdata),
    .rvalid_o(mem_rvalid)
  );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
////////////////////////////////////////
// Testbench clock and reset generator
////////////////////////////////////////

`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held low for 8 cycles
  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb_memcopy_assert.sv
////////////////////////////////////////
// Bound assertions on engine requests,
// response routing and done interrupt
////////////////////////////////////////

`default_nettype none

module tb_memcopy_assert (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        eng_req_i,
  input logic        eng_gnt_i,
  input logic        eng_we_i,
  input logic [31:0] eng_addr_i,
  input logic [31:0] eng_wdata_i,
  input logic [3:0]  eng_be_i,
  input logic        eng_rvalid_i,
  input logic        host_gnt_i,
  input logic        host_rvalid_i,
  input logic        done_irq_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions
  int fail_count = 0;

  // Engine request and its fields hold until granted
  eng_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    eng_req_i && !eng_gnt_i |=>
      eng_req_i && $stable({eng_we_i, eng_addr_i, eng_wdata_i, eng_be_i}))
    else begin
      $error("engine request changed before its grant");
      fail_count++;
    end

  // A response reaches only the master granted one cycle earlier
  eng_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    eng_rvalid_i |-> $past(eng_gnt_i))
    else begin
      $error("engine rvalid without an engine grant in the previous cycle");
      fail_count++;
    end

  host_rvalid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    host_rvalid_i |-> $past(host_gnt_i))
    else begin
      $error("host rvalid without a host grant in the previous cycle");
      fail_count++;
    end

  // Interrupt is a single-cycle pulse
  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_irq_i |=> !done_irq_i)
    else begin
      $error("done_irq_o high for more than one cycle");
      fail_count++;
    end

endmodule

bind memcopy_subsys tb_memcopy_assert assert0 (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .eng_req_i    (eng_req),
  .eng_gnt_i    (eng_gnt),
  .eng_we_i     (eng_we),
  .eng_addr_i   (eng_addr),
  .eng_wdata_i  (eng_wdata),
  .eng_be_i     (eng_be),
  .eng_rvalid_i (eng_rvalid),
  .host_gnt_i   (host_gnt_o),
  .host_rvalid_i(host_rvalid_o),
  .done_irq_i   (done_irq_o)
);

`default_nettype wire

// File: tb_memcopy.sv
////////////////////////////////////////
// Memory-copy testbench top: file-driven
// stimulus, memory mirror and checks
////////////////////////////////////////

`default_nettype none

module tb_memcopy;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_WORDS  = 128;
  localparam int WAIT_LIMIT = 64;
  localparam int COPY_LIMIT = 4000;

  // Register offsets
  localparam logic [31:0] OFF_SRC    = 32'h00;
  localparam logic [31:0] OFF_DST    = 32'h04;
  localparam logic [31:0] OFF_SIZE   = 32'h08;
  localparam logic [31:0] OFF_START  = 32'h0C;
  localparam logic [31:0] OFF_STATUS = 32'h10;
  localparam logic [31:0] OFF_BAD    = 32'h14;

  logic        clk_i;
  logic        rst_n_i;
  logic        reg_valid_i;
  logic        reg_write_i;
  logic [4:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic [31:0] reg_rdata_o;
  logic        reg_ready_o;
  logic        reg_error_o;
  logic        host_req_i;
  logic        host_we_i;
  logic [31:0] host_addr_i;
  logic [31:0] host_wdata_i;
  logic [3:0]  host_be_i;
  logic        host_gnt_o;
  logic [31:0] host_rdata_o;
  logic        host_rvalid_o;
  logic        done_irq_o;

  // Expected memory contents
  logic [31:0] mirror [NUM_WORDS];

  int     errors     = 0;
  int     checks     = 0;
  int     cycle_cnt  = 0;
  int     done_count = 0;
  int     done_cycle = 0;
  int     reg_cycle  = 0;
  integer seed       = 18;

  tb_clkgen clkgen0 (
    .clk_o  (clk_i),
    .rst_n_o(rst_n_i)
  );

  memcopy_subsys #(
    .NUM_WORDS(NUM_WORDS)
  ) dut0 (
    .clk_i,
    .rst_n_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .reg_ready_o,
    .reg_error_o,
    .host_req_i,
    .host_we_i,
    .host_addr_i,
    .host_wdata_i,
    .host_be_i,
    .host_gnt_o,
    .host_rdata_o,
    .host_rvalid_o,
    .done_irq_o
  );

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Done pulses seen mid-cycle
  always @(negedge clk_i) begin
    if (rst_n_i && done_irq_o) begin
      done_count = done_count + 1;
      done_cycle = cycle_cnt;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      errors++;
    end
  endtask

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % NUM_WORDS);
  endfunction

  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
  endfunction

  // Word index lies inside a copy range, with wrap at the memory depth
  function automatic logic in_range(input int widx, input logic [31:0] base,
                                    input logic [31:0] size);
    int rel;
    rel = (widx + NUM_WORDS - word_index(base)) % NUM_WORDS;
    return rel < int'(size);
  endfunction

  task automatic host_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    int   n;
    logic got;
    rdata = '0;
    n     = 0;
    got   = 1'b0;
    @(posedge clk_i);
    #1;
    host_req_i   = 1'b1;
    host_we_i    = we;
    host_addr_i  = addr;
    host_wdata_i = wdata;
    host_be_i    = 4'hF;
    // Request held until the grant cycle ends
    while (!got && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      got = host_gnt_o;
      n++;
      @(posedge clk_i);
    end
    #1;
    host_req_i = 1'b0;
    if (!got) begin
      $display("Host request to address 0x%08h was never granted", addr);
      errors++;
    end else begin
      n   = 0;
      got = 1'b0;
      while (!got && n < WAIT_LIMIT) begin
        @(negedge clk_i);
        if (host_rvalid_o) begin
          got   = 1'b1;
          rdata = host_rdata_o;
        end
        n++;
      end
      if (!got) begin
        $display("No host response came back for address 0x%08h", addr);
        errors++;
      end
    end
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    host_access(1'b1, addr, data, unused_rd);
    mirror[word_index(addr)] = data;
  endtask

  task automatic host_read_check(input logic [31:0] addr, input logic [31:0] expected);
    logic [31:0] rd;
    host_access(1'b0, addr, 32'h0, rd);
    check_value("host_rdata_o", rd, expected);
  endtask

  task automatic reg_access(input logic write, input logic [31:0] off,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(posedge clk_i);
    #1;
    reg_valid_i = 1'b1;
    reg_write_i = write;
    reg_addr_i  = off[4:0];
    reg_wdata_i = wdata;
    @(negedge clk_i);
    check_value("reg_ready_o", {31'b0, reg_ready_o}, 32'h1);
    rdata     = reg_rdata_o;
    err       = reg_error_o;
    reg_cycle = cycle_cnt;
    @(posedge clk_i);
    #1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
  endtask

  task automatic reg_write_check(input logic [31:0] off, input logic [31:0] data,
                                 input logic exp_err);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b1, off, data, rd, err);
    check_value("reg_error_o", {31'b0, err}, {31'b0, exp_err});
  endtask

  task automatic reg_read_check(input logic [31:0] off, input logic [31:0] expected,
                                input logic exp_err);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b0, off, 32'h0, rd, err);
    check_value("reg_rdata_o", rd, expected);
    check_value("reg_error_o", {31'b0, err}, {31'b0, exp_err});
  endtask

  task automatic wait_done(input int target);
    int n;
    n = 0;
    while (done_count < target && n < COPY_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (done_count < target) begin
      $display("The copy did not raise done_irq_o before the timeout");
      errors++;
    end
  endtask

  // Program and start a copy, probe it while busy, then check the result
  task automatic run_copy(input logic [31:0] src, input logic [31:0] dst,
                          input logic [31:0] size, input int nreads);
    int target;
    int start_cycle;
    int widx;
    int tries;
    reg_write_check(OFF_SRC, src, 1'b0);
    reg_write_check(OFF_DST, dst, 1'b0);
    reg_write_check(OFF_SIZE, size, 1'b0);
    target = done_count + 1;
    reg_write_check(OFF_START, 32'h1, 1'b0);
    start_cycle = reg_cycle;
    if (size[15:0] == 16'h0) begin
      wait_done(target);
      check_value("done_irq_o delay", 32'(done_cycle - start_cycle), 32'd2);
    end else begin
      // Busy with done cleared by the new start
      reg_read_check(OFF_STATUS, 32'h1, 1'b0);
      reg_write_check(OFF_START, 32'h1, 1'b1);
      reg_write_check(OFF_STATUS, 32'h3, 1'b1);
      reg_write_check(OFF_BAD, 32'hFFFF_FFFF, 1'b1);
      for (int i = 0; i < nreads; i++) begin
        tries = 0;
        do begin
          widx = int'($unsigned($random(seed)) % NUM_WORDS);
          tries++;
        end while ((in_range(widx, src, size) || in_range(widx, dst, size)) && tries < 64);
        if (!in_range(widx, src, size) && !in_range(widx, dst, size)) begin
          host_read_check(32'(widx * 4), mirror[widx]);
        end
      end
      wait_done(target);
    end
    reg_read_check(OFF_STATUS, 32'h2, 1'b0);
    reg_read_check(OFF_SRC, src, 1'b0);
    reg_read_check(OFF_DST, dst, 1'b0);
    reg_read_check(OFF_SIZE, {16'h0, size[15:0]}, 1'b0);
    // Forward word copy in the mirror
    for (int i = 0; i < int'(size[15:0]); i++) begin
      mirror[word_index(dst + 32'(i * 4))] = mirror[word_index(src + 32'(i * 4))];
    end
    for (int i = 0; i < int'(size[15:0]); i++) begin
      host_read_check(src + 32'(i * 4), mirror[word_index(src + 32'(i * 4))]);
      host_read_check(dst + 32'(i * 4), mirror[word_index(dst + 32'(i * 4))]);
    end
  endtask

  initial begin
    string       line;
    integer      fd;
    int          n;
    logic [7:0]  cmd;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    reg_valid_i  = 1'b0;
    reg_write_i  = 1'b0;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    host_be_i    = '0;

    n = 0;
    while (!rst_n_i && n < 64) begin
      @(negedge clk_i);
      n++;
    end
    if (!rst_n_i) begin
      $display("Reset was never released");
      errors++;
    end

    // Outputs idle after reset
    @(negedge clk_i);
    check_value("host_gnt_o", {31'b0, host_gnt_o}, 32'h0);
    check_value("host_rvalid_o", {31'b0, host_rvalid_o}, 32'h0);
    check_value("done_irq_o", {31'b0, done_irq_o}, 32'h0);
    check_value("reg_ready_o", {31'b0, reg_ready_o}, 32'h0);
    check_value("reg_error_o", {31'b0, reg_error_o}, 32'h0);

    // Pointers and size clear after reset
    reg_read_check(OFF_DST, 32'h0, 1'b0);
    reg_read_check(OFF_SIZE, 32'h0, 1'b0);

    // Known contents everywhere before the file commands
    for (int w = 0; w < NUM_WORDS; w++) begin
      host_write(32'(w * 4), fill_pattern(32'(w * 4)));
    end

    fd = $fopen("memcopy_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file memcopy_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n    = $fgets(line, fd);
        if (n > 0) begin
          cmd = 8'h0;
          f0  = '0;
          f1  = '0;
          f2  = '0;
          f3  = '0;
          n   = $sscanf(line, "%c %h %h %h %h", cmd, f0, f1, f2, f3);
          case (cmd)
            "W": host_write(f0, f1);
            "R": host_read_check(f0, f1);
            "G": reg_write_check(f0, f1, f2[0]);
            "Q": reg_read_check(f0, f1, f2[0]);
            "C": run_copy(f0, f1, f2, 0);
            "X": run_copy(f0, f1, f2, int'(f3));
            "#", "\n", " ", 8'h0D, 8'h00: ;
            default: begin
              $display("Unknown command letter in the stimulus file");
              errors++;
            end
          endcase
        end
      end
      $fclose(fd);
    end

    // Whole memory against the mirror
    for (int w = 0; w < NUM_WORDS; w++) begin
      host_read_check(32'(w * 4), mirror[w]);
    end

    // Bound assertion failures count as errors
    errors = errors + dut0.assert0.fail_count;

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
bus_pkg.sv
memcopy_pkg.sv
memcopy_regs.sv
memcopy_engine.sv
obi_arbiter.sv
slow_memory.sv
memcopy_subsys.sv
tb_clkgen.sv
tb_memcopy_assert.sv
tb_memcopy.sv

// File: Makefile
# Verilator build and run of the memory-copy subsystem testbench

SRCS := $(shell cat sim.f)

all: run

obj_dir/Vtb_memcopy: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_memcopy -f sim.f -o Vtb_memcopy

run: obj_dir/Vtb_memcopy memcopy_input.txt
	./obj_dir/Vtb_memcopy > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "Done: errors found" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: memcopy_input.txt
# W addr data, R addr expected, G offset data error, Q offset expected error
# C src dst size, X src dst size reads; all fields hex
Q 00000010 00000000 0
Q 00000000 00000000 0
W 00000000 11111111
W 00000004 22222222
W 00000008 33333333
W 0000000c 44444444
R 00000000 11111111
R 00000004 22222222
R 00000008 33333333
R 0000000c 44444444
G 00000000 00000040 0
G 00000004 00000100 0
G 00000008 00000005 0
Q 00000000 00000040 0
Q 00000004 00000100 0
Q 00000008 00000005 0
Q 0000000c 00000000 1
G 00000010 00000001 1
G 00000014 00000001 1
C 00000000 00000080 00000008
R 00000084 22222222
R 0000008c 44444444
C 00000000 00000100 00000000
X 00000040 00000140 00000010 00000010
